// ==== Makefile ====
TOOL      = verilator
TOP       = mipsCpuBusTb
FILELIST  = sources.f
LINTFLAGS = --lint-only --timing -Wall
SIMFLAGS  = --binary --timing --assert -Wno-fatal
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/cpuControl.sv ====
`timescale 1ns/1ps
// Sequencer for fetch, execute, memory and halt
// Bus strobes are registered so they stay low through reset
// Halt is left only by reset
module cpuControl (
    input  logic clk,
    input  logic reset,
    input  logic waitrequest,
    input  logic isMemOp,     // Valid in exec and mem
    input  logic isStore,
    input  logic nextIsZero,  // pc about to become zero
    output logic read,
    output logic write,
    output logic active,
    output logic loadInstr,
    output logic execStrobe,
    output logic memDone,
    output logic advance
);
    import mipsPkg::*;

    cpuStateT state;
    cpuStateT nextState;

    // Completion pulses
    assign loadInstr  = (state == stateFetch) && read && !waitrequest;
    assign execStrobe = (state == stateExec);
    assign memDone    = (state == stateMem) && !waitrequest;  // Strobe always up in mem
    assign advance    = (execStrobe && !isMemOp) || memDone;
    assign active     = (state != stateHalt);

    always_comb begin
        nextState = state;
        case (state)
            stateFetch: begin
                if (loadInstr) begin
                    nextState = stateExec;
                end
            end
            stateExec: begin
                if (isMemOp) begin
                    nextState = stateMem;
                end else begin
                    nextState = nextIsZero ? stateHalt : stateFetch;
                end
            end
            stateMem: begin
                if (memDone) begin
                    nextState = nextIsZero ? stateHalt : stateFetch;
                end
            end
            default: begin
                nextState = stateHalt;  // Parked
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateFetch;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            state <= nextState;
            // Strobes follow the state being entered
            read  <= (nextState == stateFetch) || ((nextState == stateMem) && !isStore);
            write <= (nextState == stateMem) && isStore;
        end
    end

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/1ps
// Instruction register, decode, ALU and branch/jump targets
// Unknown encodings write nothing and fall through to pc+4
// Memory addresses are word aligned with the low two bits dropped
module executeUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic          loadInstr,
    input  logic          execStrobe,
    input  logic          memDone,
    input  mipsPkg::wordT readdata,
    input  mipsPkg::wordT pc,
    regFileIf.execute     regs,
    output logic          isMemOp,
    output logic          isStore,
    output logic          branchTaken,
    output mipsPkg::wordT branchTarget,
    output mipsPkg::wordT memAddress,
    output mipsPkg::wordT storeData
);
    import mipsPkg::*;

    wordT instr;
    logic memServed;  // Access of current LW/SW already done
    opcodeT opcode;
    functT funct;
    logic [regAddrWidth-1:0] rs, rt, rd;
    logic [4:0] shamt;
    wordT signImm, zeroImm, rsVal, rtVal, pcPlus4, aluResult;
    logic aluWrites;
    logic [regAddrWidth-1:0] aluDest;

    // Field split
    assign opcode  = opcodeT'(instr[31:26]);
    assign funct   = functT'(instr[5:0]);
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign shamt   = instr[10:6];
    assign signImm = {{16{instr[15]}}, instr[15:0]};
    assign zeroImm = {16'b0, instr[15:0]};  // ANDI, ORI, XORI
    assign pcPlus4 = pc + wordT'(4);

    assign regs.readAddrA = rs;
    assign regs.readAddrB = rt;
    assign rsVal = regs.readDataA;
    assign rtVal = regs.readDataB;

    // Also steers the bus address mux and drops once the access is done
    assign isMemOp    = ((opcode == opLw) || (opcode == opSw)) && !memServed;
    assign isStore    = (opcode == opSw);
    assign memAddress = (rsVal + signImm) & ~wordT'(3);  // Base plus offset
    assign storeData  = rtVal;

    always_comb begin
        aluResult    = '0;
        aluWrites    = 1'b0;
        aluDest      = rt;  // I-type default
        branchTaken  = 1'b0;
        branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
        case (opcode)
            opR: begin
                aluDest   = rd;
                aluWrites = 1'b1;
                case (funct)
                    fnAddu: aluResult = rsVal + rtVal;
                    fnSubu: aluResult = rsVal - rtVal;
                    fnAnd:  aluResult = rsVal & rtVal;
                    fnOr:   aluResult = rsVal | rtVal;
                    fnXor:  aluResult = rsVal ^ rtVal;
                    fnSlt:  aluResult = wordT'($signed(rsVal) < $signed(rtVal));
                    fnSltu: aluResult = wordT'(rsVal < rtVal);
                    fnSll:  aluResult = rtVal << shamt;
                    fnSrl:  aluResult = rtVal >> shamt;
                    fnSra:  aluResult = $signed(rtVal) >>> shamt;  // Keeps sign
                    fnJr: begin
                        aluWrites    = 1'b0;
                        branchTaken  = 1'b1;
                        branchTarget = rsVal;
                    end
                    default: aluWrites = 1'b0;  // No-op
                endcase
            end
            opAddiu: begin
                aluResult = rsVal + signImm;
                aluWrites = 1'b1;
            end
            opSlti: begin
                aluResult = wordT'($signed(rsVal) < $signed(signImm));
                aluWrites = 1'b1;
            end
            opSltiu: begin
                aluResult = wordT'(rsVal < signImm);  // Sign-extended imm compared unsigned
                aluWrites = 1'b1;
            end
            opAndi: begin
                aluResult = rsVal & zeroImm;
                aluWrites = 1'b1;
            end
            opOri: begin
                aluResult = rsVal | zeroImm;
                aluWrites = 1'b1;
            end
            opXori: begin
                aluResult = rsVal ^ zeroImm;
                aluWrites = 1'b1;
            end
            opLui: begin
                aluResult = {instr[15:0], 16'b0};
                aluWrites = 1'b1;
            end
            opBeq: branchTaken = (rsVal == rtVal);
            opBne: branchTaken = (rsVal != rtVal);
            opJ: begin
                branchTaken  = 1'b1;
                branchTarget = {pcPlus4[31:28], instr[25:0], 2'b00};  // Region of pc+4
            end
            default: ;  // LW, SW and unknown
        endcase
    end

    // ALU result in exec, load data at the end of the mem phase
    assign regs.writeEnable = (execStrobe && aluWrites) || (memDone && !isStore);
    assign regs.writeAddr   = aluDest;  // rt for LW
    assign regs.writeData   = memDone ? readdata : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr     <= '0;  // SLL r0 acts as a no-op
            memServed <= 1'b0;
        end else if (loadInstr) begin
            instr     <= readdata;
            memServed <= 1'b0;
        end else if (memDone) begin
            memServed <= 1'b1;
        end
    end

endmodule

// ==== design/mipsCpuBus.sv ====
`timescale 1ns/1ps
// MIPS32 subset core as an Avalon-MM master with waitrequest
// Word accesses only, byteenable is always all ones
// Halts when pc reaches zero, restart by reset
module mipsCpuBus (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output mipsPkg::wordT registerV0,
    output mipsPkg::wordT address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output mipsPkg::wordT writedata,
    output logic [3:0]    byteenable,
    input  mipsPkg::wordT readdata
);
    import mipsPkg::*;

    localparam int regCount = 32;

    logic loadInstr, execStrobe, memDone, advance;
    logic isMemOp, isStore, branchTaken, nextIsZero;
    wordT pc, branchTarget, memAddress, storeData;

    regFileIf #(.regCount(regCount)) regBus ();

    // pc for fetch, LW/SW address for the mem phase
    assign address    = isMemOp ? memAddress : pc;
    assign writedata  = storeData;
    assign byteenable = 4'hF;

    cpuControl i_cpuControl (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .isMemOp     (isMemOp),
        .isStore     (isStore),
        .nextIsZero  (nextIsZero),
        .read        (read),
        .write       (write),
        .active      (active),
        .loadInstr   (loadInstr),
        .execStrobe  (execStrobe),
        .memDone     (memDone),
        .advance     (advance)
    );

    programCounter #(.resetAddr(resetVector)) i_programCounter (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc),
        .nextIsZero   (nextIsZero)
    );

    registerFile #(.regCount(regCount)) i_registerFile (
        .clk        (clk),
        .reset      (reset),
        .regs       (regBus.storage),
        .registerV0 (registerV0)
    );

    executeUnit i_executeUnit (
        .clk          (clk),
        .reset        (reset),
        .loadInstr    (loadInstr),
        .execStrobe   (execStrobe),
        .memDone      (memDone),
        .readdata     (readdata),
        .pc           (pc),
        .regs         (regBus.execute),
        .isMemOp      (isMemOp),
        .isStore      (isStore),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .memAddress   (memAddress),
        .storeData    (storeData)
    );

endmodule

// ==== design/mipsPkg.sv ====
// Shared types and constants for the MIPS32 subset core
// Only the kept opcodes and function codes are listed, others decode as no-ops
// Word width is fixed at 32, the core is not meant to be resized
package mipsPkg;

    localparam int wordWidth    = 32;  // Data and address width
    localparam int regAddrWidth = 5;   // Register number width

    typedef logic [wordWidth-1:0] wordT;

    localparam wordT resetVector = 32'hBFC00000;  // First fetch address

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        opR     = 6'd0,   // R-type, see functT
        opJ     = 6'd2,
        opBeq   = 6'd4,
        opBne   = 6'd5,
        opAddiu = 6'd9,
        opSlti  = 6'd10,
        opSltiu = 6'd11,
        opAndi  = 6'd12,  // Zero-extended imm
        opOri   = 6'd13,  // Zero-extended imm
        opXori  = 6'd14,  // Zero-extended imm
        opLui   = 6'd15,
        opLw    = 6'd35,
        opSw    = 6'd43
    } opcodeT;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        fnSll  = 6'd0,   // Shift by shamt only
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnJr   = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functT;

    // Instruction sequencing states
    typedef enum logic [1:0] {
        stateFetch = 2'd0,  // Bus read at pc
        stateExec  = 2'd1,  // Single execute cycle
        stateMem   = 2'd2,  // LW or SW bus access
        stateHalt  = 2'd3   // Reached address zero, stuck until reset
    } cpuStateT;

endpackage

// ==== design/programCounter.sv ====
`timescale 1ns/1ps
// Moves only on advance, by one word or to the target from execute
// Targets are used as given, alignment is the program's concern
module programCounter #(
    parameter mipsPkg::wordT resetAddr = mipsPkg::resetVector
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          advance,
    input  logic          branchTaken,
    input  mipsPkg::wordT branchTarget,
    output mipsPkg::wordT pc,
    output logic          nextIsZero
);
    import mipsPkg::*;

    wordT pcPlus4;
    wordT nextPc;

    assign pcPlus4 = pc + wordT'(4);  // Sequential word
    assign nextPc  = branchTaken ? branchTarget : pcPlus4;

    // Lets control pick halt in the same cycle as the update
    assign nextIsZero = (nextPc == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetAddr;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

endmodule

// ==== design/regFileIf.sv ====
`timescale 1ns/1ps
// Two read ports and one write port between execute unit and register file
// Reads are combinational, the write lands on the clock edge
interface regFileIf #(
    parameter int regCount = 32
);
    import mipsPkg::*;

    localparam int addrWidth = $clog2(regCount);

    logic [addrWidth-1:0] readAddrA;   // Usually rs
    logic [addrWidth-1:0] readAddrB;   // Usually rt
    wordT                 readDataA;
    wordT                 readDataB;
    logic                 writeEnable;
    logic [addrWidth-1:0] writeAddr;   // rd or rt
    wordT                 writeData;

    modport execute (
        output readAddrA, readAddrB, writeEnable, writeAddr, writeData,
        input  readDataA, readDataB
    );

    modport storage (
        input  readAddrA, readAddrB, writeEnable, writeAddr, writeData,
        output readDataA, readDataB
    );

endinterface

// ==== design/registerFile.sv ====
`timescale 1ns/1ps
// General registers, r0 reads as zero and ignores writes
// All entries clear on reset
module registerFile #(
    parameter int regCount = 32
) (
    input  logic          clk,
    input  logic          reset,
    regFileIf.storage     regs,
    output mipsPkg::wordT registerV0
);
    import mipsPkg::*;

    wordT regArray [regCount];

    // Combinational reads
    assign regs.readDataA = regArray[regs.readAddrA];
    assign regs.readDataB = regArray[regs.readAddrB];

    assign registerV0 = regArray[2];  // v0 tap for the top level

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regArray[i] <= '0;
            end
        end else if (regs.writeEnable && (regs.writeAddr != '0)) begin
            regArray[regs.writeAddr] <= regs.writeData;
        end
    end

endmodule

// ==== dv/mipsCpuBusTb.sv ====
`timescale 1ns/1ps
// Random MIPS subset programs checked against an instruction-set model in the testbench
// Memory answers with random wait states, data window sits at 0x1000
// Second run stresses signed compares, arithmetic shifts, logic immediates and r0 writes
module mipsCpuBusTb;
    import mipsPkg::*;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       waitrequest = 1'b0;
    wordT       readdata = '0;
    logic       active, write, read;
    wordT       registerV0, address, writedata;
    logic [3:0] byteenable;

    logic [31:0] lfsr = 32'haa02265b;
    wordT dutMem [wordT];   // Bus side memory, keyed by word address
    wordT refMem [wordT];   // Model copy
    wordT refRegs [32];
    wordT progPc;           // Next free program slot
    logic expWrite [$];     // Expected transfers in bus order
    wordT expAddr [$];
    wordT expData [$];
    int   checkCount = 0;

    localparam logic [5:0] rFuncts [10] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor,
                                            fnSlt, fnSltu, fnSll, fnSrl, fnSra};
    localparam logic [5:0] iOps [7] = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};

    mipsCpuBus i_mipsCpuBus (.*);

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [4:0] pickReg();  // r1..r7
        logic [4:0] r;
        r = 5'(randBits(3));
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic logic [4:0] destReg();  // Keeps r6 as data base
        logic [4:0] r;
        r = pickReg();
        return (r == 5'd6) ? 5'd5 : r;
    endfunction

    function automatic wordT rIns(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iIns(input logic [5:0] op, input logic [4:0] rs, rt,
                                  input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT refWord(input wordT a);
        return refMem.exists(a >> 2) ? refMem[a >> 2] : '0;
    endfunction

    function automatic wordT dutWord(input wordT a);
        return dutMem.exists(a >> 2) ? dutMem[a >> 2] : '0;
    endfunction

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checkCount++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic emit(input wordT w);
        dutMem[progPc >> 2] = w;
        refMem[progPc >> 2] = w;
        progPc += 4;
    endtask

    task automatic pushEvent(input logic w, input wordT a, input wordT d);
        expWrite.push_back(w);
        expAddr.push_back(a);
        expData.push_back(d);
    endtask

    task automatic genRandom(input int count);
        logic [4:0] sel;
        int skip;
        for (int i = 0; i < count; i++) begin
            sel = 5'(randBits(5));
            skip = int'(randBits(2));
            if (skip > count - i - 1) begin
                skip = count - i - 1;  // Forward only, never past the tail
            end
            if (sel < 10) begin
                emit(rIns(pickReg(), pickReg(), destReg(), 5'(randBits(5)), rFuncts[sel]));
            end else if (sel < 17) begin
                emit(iIns(iOps[sel - 10], pickReg(), destReg(), 16'(randBits(16))));
            end else if (sel < 19) begin
                emit(iIns((sel == 17) ? opBeq : opBne, pickReg(), pickReg(), 16'(skip)));
            end else if (sel == 19) begin
                emit({opJ, 26'((progPc + 4 + 4 * skip) >> 2)});
            end else if (sel < 26) begin
                emit(iIns(opLw, 5'd6, destReg(), 16'(4 * randBits(4))));
            end else begin
                emit(iIns(opSw, 5'd6, pickReg(), 16'(4 * randBits(4))));
            end
        end
    endtask

    task automatic genCorner(input int count);
        logic [4:0] a;
        for (int i = 0; i < count; i++) begin
            a = pickReg();
            emit(iIns(opLui, 5'd0, a, 16'h8000 | 16'(randBits(15))));  // Negative value
            emit(iIns(opOri, a, a, 16'(randBits(16))));
            emit(rIns(a, pickReg(), pickReg(), 5'd0, fnSlt));
            emit(rIns(a, pickReg(), pickReg(), 5'd0, fnSltu));
            emit(rIns(5'd0, a, pickReg(), 5'(randBits(5)), fnSra));
            emit(iIns(iOps[3 + i % 3], a, pickReg(), 16'h8000 | 16'(randBits(15))));
            emit(iIns(opSlti, a, pickReg(), 16'h8000 | 16'(randBits(15))));
            emit(iIns(opSltiu, pickReg(), pickReg(), 16'(randBits(16))));
            emit(iIns(opAddiu, a, 5'd0, 16'(randBits(16))));  // r0 stays zero
            emit(rIns(a, pickReg(), 5'd0, 5'd0, fnXor));
        end
    endtask

    task automatic loadProgram(input logic corner);
        wordT a;
        dutMem.delete();
        refMem.delete();
        expWrite.delete();
        expAddr.delete();
        expData.delete();
        for (int w = 0; w < 16; w++) begin
            a = 32'h1000 + 4 * w;
            dutMem[a >> 2] = (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
            refMem[a >> 2] = dutMem[a >> 2];
        end
        progPc = resetVector;
        if (corner) begin
            genCorner(8);
        end else begin
            emit(iIns(opLui, 5'd0, 5'd6, 16'h0000));
            emit(iIns(opOri, 5'd6, 5'd6, 16'h1000));
            genRandom(60);
        end
        // Checksum of r1..r7 into v0, then jump to zero
        emit(rIns(5'd1, 5'd2, 5'd8, 5'd0, fnAddu));
        for (int r = 3; r < 8; r++) begin
            emit(rIns(5'd8, 5'(r), 5'd8, 5'd0, fnAddu));
        end
        emit(rIns(5'd8, 5'd0, 5'd2, 5'd0, fnAddu));
        emit(rIns(5'd9, 5'd0, 5'd9, 5'd0, fnAnd));
        emit(rIns(5'd9, 5'd0, 5'd0, 5'd0, fnJr));
    endtask

    // Instruction-set model, records every expected bus transfer
    task automatic runModel();
        wordT pc, ins, a, b, res, nextPc, sImm, zImm, ea;
        logic [4:0] dst;
        logic wr;
        int steps;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        pc = resetVector;
        steps = 0;
        while (pc != '0) begin
            assert (steps < 5000) else begin
                $display("Model did not reach address zero");
                abortRun();
            end
            steps++;
            pushEvent(1'b0, pc, '0);
            ins = refWord(pc);
            a = refRegs[ins[25:21]];
            b = refRegs[ins[20:16]];
            sImm = {{16{ins[15]}}, ins[15:0]};
            zImm = {16'h0, ins[15:0]};
            ea = (a + sImm) & ~32'h3;
            nextPc = pc + 4;
            wr = 1'b1;
            dst = ins[20:16];
            res = '0;
            case (ins[31:26])
                opR: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fnAddu: res = a + b;
                        fnSubu: res = a - b;
                        fnAnd:  res = a & b;
                        fnOr:   res = a | b;
                        fnXor:  res = a ^ b;
                        fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSltu: res = (a < b) ? 32'd1 : 32'd0;
                        fnSll:  res = b << ins[10:6];
                        fnSrl:  res = b >> ins[10:6];
                        fnSra:  res = $signed(b) >>> ins[10:6];
                        fnJr: begin
                            wr = 1'b0;
                            nextPc = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = a + sImm;
                opSlti:  res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                opSltiu: res = (a < sImm) ? 32'd1 : 32'd0;
                opAndi:  res = a & zImm;
                opOri:   res = a | zImm;
                opXori:  res = a ^ zImm;
                opLui:   res = {ins[15:0], 16'h0};
                opBeq, opBne: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == opBeq)) begin
                        nextPc = pc + 4 + (sImm << 2);
                    end
                end
                opJ: begin
                    wr = 1'b0;
                    nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                end
                opLw: begin
                    res = refWord(ea);
                    pushEvent(1'b0, ea, '0);
                end
                opSw: begin
                    wr = 1'b0;
                    pushEvent(1'b1, ea, b);
                    refMem[ea >> 2] = b;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                refRegs[dst] = res;
            end
            pc = nextPc;
        end
    endtask

    task automatic runDut();
        logic stalled, req, lastRead, lastWrite;
        wordT lastAddr, lastData;
        int cycles;
        stalled = 1'b0;
        @(posedge clk);
        #10 reset = 1'b1;
        waitrequest = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        checkWord("read", read, 0);
        checkWord("write", write, 0);
        checkWord("active", active, 1);
        reset = 1'b0;
        cycles = 0;
        while (active) begin
            @(posedge clk);
            #10;
            assert (cycles < 50000) else begin
                $display("Timeout waiting for the DUT to halt");
                abortRun();
            end
            cycles++;
            if (stalled) begin  // Request must hold through waitrequest
                checkWord("address", address, lastAddr);
                checkWord("read", read, lastRead);
                checkWord("write", write, lastWrite);
                checkWord("writedata", writedata, lastData);
            end
            assert (!(read && write)) else begin
                $display("read and write are high together at %0t", $time);
                abortRun();
            end
            req = read || write;
            waitrequest = req && randBits(1);
            readdata = dutWord(address);
            if (req && !waitrequest) begin  // Completes on the next edge
                assert (expAddr.size() > 0) else begin
                    $display("DUT made a bus transfer the model does not expect");
                    abortRun();
                end
                checkWord("write", write, expWrite[0]);
                checkWord("address", {address[31:2], 2'b00}, expAddr[0]);
                if (write) begin
                    checkWord("writedata", writedata, expData[0]);
                    checkWord("byteenable", byteenable, 4'hF);
                    dutMem[address >> 2] = writedata;
                end
                void'(expWrite.pop_front());
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
            stalled = req && waitrequest;
            lastAddr = address;
            lastRead = read;
            lastWrite = write;
            lastData = writedata;
        end
        waitrequest = 1'b0;
        assert (expAddr.size() == 0) else begin
            $display("DUT halted with %0d transfers still expected", expAddr.size());
            abortRun();
        end
        checkWord("registerV0", registerV0, refRegs[2]);
        repeat (50) begin  // Quiet bus after halt
            @(posedge clk);
            #10;
            checkWord("read", read, 0);
            checkWord("write", write, 0);
            checkWord("active", active, 0);
        end
    endtask

    initial begin
        for (int pass = 0; pass < 2; pass++) begin
            loadProgram(pass == 1);
            runModel();
            runDut();
        end
        if (checkCount > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("No checks were made");
            abortRun();
        end
    end

endmodule

// ==== sources.f ====
design/mipsPkg.sv
design/regFileIf.sv
design/cpuControl.sv
design/programCounter.sv
design/registerFile.sv
design/executeUnit.sv
design/mipsCpuBus.sv
dv/mipsCpuBusTb.sv
